//--- verilog/concat_pkg.sv
// shared constants for the five-branch concat stage
// segment lengths are fixed at build time and are not programmable
// counter and pointer widths must be kept in step with the sizes below

`default_nettype none

package concat_pkg;

  ////////////////////
  // datapath
  ////////////////////

  // one feature word per strobe
  localparam int data_width = 32;

  // branches joined per frame
  localparam int num_branch = 5;
  localparam int branch_w   = 3;

  ////////////////////
  // buffering
  ////////////////////

  // entries per branch fifo, power of two
  localparam int fifo_depth  = 16;
  localparam int fifo_addr_w = 4;

  ////////////////////
  // frame layout
  ////////////////////

  // words per branch per frame, 20 words total
  localparam int unsigned seg_len [num_branch] = '{3, 5, 2, 4, 6};

  // wide enough for the longest segment minus one
  localparam int seg_cnt_w = 3;

  // arbiter states
  // drain pops the granted branch, switch advances the grant
  typedef enum logic [0:0] {
    ARB_DRAIN  = 1'b0,
    ARB_SWITCH = 1'b1
  } arb_state_t;

endpackage

`default_nettype wire

//--- verilog/branch_fifo.sv
// per-branch buffer, show-ahead read, no almost-full
// a push into a full fifo is lost unless a pop happens in the same cycle
// overflow is sticky and only reset clears it

`timescale 1ns/1ps
`default_nettype none

module branch_fifo (
  input  wire                                clk,
  input  wire                                reset,
  input  wire                                push,
  input  wire [concat_pkg::data_width-1:0]   push_data,
  input  wire                                pop,
  output logic [concat_pkg::data_width-1:0]  pop_data,
  output logic                               empty,
  output logic                               overflow
);

  ////////////////////
  // storage
  ////////////////////

  // register array, no reset on payload
  logic [concat_pkg::data_width-1:0] mem [concat_pkg::fifo_depth];

  logic [concat_pkg::fifo_addr_w-1:0] wr_ptr;
  logic [concat_pkg::fifo_addr_w-1:0] rd_ptr;
  // one extra bit so a full fifo is distinguishable from empty
  logic [concat_pkg::fifo_addr_w:0]   count;

  logic full;
  logic do_pop;
  logic do_push;

  ////////////////////
  // status
  ////////////////////

  assign empty = (count == '0);
  assign full  = (count == (concat_pkg::fifo_addr_w + 1)'(concat_pkg::fifo_depth));

  // pop only counts when there is something to pop
  assign do_pop  = pop && !empty;
  // full slot frees up if a pop lands on the same edge
  assign do_push = push && (!full || do_pop);

  // show-ahead, head word visible while not empty
  assign pop_data = mem[rd_ptr];

  ////////////////////
  // write side
  ////////////////////

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (do_push) begin
      // wraps naturally at fifo_depth
      wr_ptr <= wr_ptr + concat_pkg::fifo_addr_w'(1);
    end
  end

  ////////////////////
  // read side
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (do_pop) begin
      rd_ptr <= rd_ptr + concat_pkg::fifo_addr_w'(1);
    end
  end

  // occupancy, unchanged on simultaneous push and pop
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else begin
      case ({do_push, do_pop})
        2'b10:   count <= count + (concat_pkg::fifo_addr_w + 1)'(1);
        2'b01:   count <= count - (concat_pkg::fifo_addr_w + 1)'(1);
        default: count <= count;
      endcase
    end
  end

  // sticky drop flag
  always_ff @(posedge clk) begin
    if (reset) begin
      overflow <= 1'b0;
    end else if (push && !do_push) begin
      overflow <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/concat_arbiter.sv
// owns the shared output bus, grants branches in fixed order 0..4
// waits on an empty granted fifo, never skips to a later branch
// one idle cycle between segments, one register stage to the output

`timescale 1ns/1ps
`default_nettype none

module concat_arbiter (
  input  wire                                 clk,
  input  wire                                 reset,
  input  wire [concat_pkg::num_branch-1:0]    empty,
  input  wire [concat_pkg::data_width-1:0]    pop_data0,
  input  wire [concat_pkg::data_width-1:0]    pop_data1,
  input  wire [concat_pkg::data_width-1:0]    pop_data2,
  input  wire [concat_pkg::data_width-1:0]    pop_data3,
  input  wire [concat_pkg::data_width-1:0]    pop_data4,
  output logic [concat_pkg::num_branch-1:0]   pop,
  output logic [concat_pkg::data_width-1:0]   out,
  output logic                                valid_out,
  output logic                                last_out
);

  ////////////////////
  // control state
  ////////////////////

  concat_pkg::arb_state_t state;

  // branch currently owning the bus
  logic [concat_pkg::branch_w-1:0]  grant;
  // words popped so far in this segment
  logic [concat_pkg::seg_cnt_w-1:0] seg_cnt;

  logic                             pop_now;
  logic                             seg_end;
  logic                             last_branch;
  logic [concat_pkg::seg_cnt_w-1:0] seg_top;
  logic [concat_pkg::data_width-1:0] branch_word [concat_pkg::num_branch];
  logic [concat_pkg::data_width-1:0] sel_word;

  ////////////////////
  // read mux
  ////////////////////

  // gather head words so the grant can index them
  assign branch_word[0] = pop_data0;
  assign branch_word[1] = pop_data1;
  assign branch_word[2] = pop_data2;
  assign branch_word[3] = pop_data3;
  assign branch_word[4] = pop_data4;

  assign sel_word = branch_word[grant];

  ////////////////////
  // pop decision
  ////////////////////

  // pop only in drain and only when the granted fifo has a word
  assign pop_now = (state == concat_pkg::ARB_DRAIN) && !empty[grant];

  // one-hot pop, only the granted line can rise
  always_comb begin
    pop = '0;
    if (pop_now) begin
      pop[grant] = 1'b1;
    end
  end

  // index of the final word of the granted segment
  assign seg_top = concat_pkg::seg_cnt_w'(concat_pkg::seg_len[grant] - 1);
  assign seg_end = (seg_cnt == seg_top);

  assign last_branch = (grant == concat_pkg::branch_w'(concat_pkg::num_branch - 1));

  ////////////////////
  // fsm
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= concat_pkg::ARB_DRAIN;
      grant   <= '0;
      seg_cnt <= '0;
    end else begin
      case (state)
        concat_pkg::ARB_DRAIN: begin
          if (pop_now) begin
            if (seg_end) begin
              // segment done, hand over next cycle
              state <= concat_pkg::ARB_SWITCH;
            end else begin
              seg_cnt <= seg_cnt + concat_pkg::seg_cnt_w'(1);
            end
          end
        end

        concat_pkg::ARB_SWITCH: begin
          // advance grant, wrap after the last branch
          if (last_branch) begin
            grant <= '0;
          end else begin
            grant <= grant + concat_pkg::branch_w'(1);
          end
          seg_cnt <= '0;
          state   <= concat_pkg::ARB_DRAIN;
        end

        default: begin
          state <= concat_pkg::ARB_DRAIN;
        end
      endcase
    end
  end

  ////////////////////
  // output register
  ////////////////////

  // payload holds its value between words
  always_ff @(posedge clk) begin
    if (pop_now) begin
      out <= sel_word;
    end
  end

  // strobes follow the pop by one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
      last_out  <= 1'b0;
    end else begin
      valid_out <= pop_now;
      // frame ends on the closing word of branch 4
      last_out  <= pop_now && seg_end && last_branch;
    end
  end

endmodule

`default_nettype wire

//--- verilog/cnn_concat_5in.sv
// five-input channel concat, output order is branch 0 through 4 per frame
// no ready on inputs or output; a full branch fifo drops and flags overflow
// overflow bit k belongs to input k+1

`timescale 1ns/1ps
`default_nettype none

module cnn_concat_5in (
  input  wire                               clk,
  input  wire                               reset,
  input  wire                               valid_in_no1,
  input  wire [concat_pkg::data_width-1:0]  in_no1,
  input  wire                               valid_in_no2,
  input  wire [concat_pkg::data_width-1:0]  in_no2,
  input  wire                               valid_in_no3,
  input  wire [concat_pkg::data_width-1:0]  in_no3,
  input  wire                               valid_in_no4,
  input  wire [concat_pkg::data_width-1:0]  in_no4,
  input  wire                               valid_in_no5,
  input  wire [concat_pkg::data_width-1:0]  in_no5,
  output wire [concat_pkg::data_width-1:0]  out,
  output wire                               valid_out,
  output wire                               last_out,
  output wire [concat_pkg::num_branch-1:0]  overflow
);

  ////////////////////
  // fifo to arbiter
  ////////////////////

  wire [concat_pkg::num_branch-1:0] fifo_empty;
  wire [concat_pkg::num_branch-1:0] fifo_pop;
  wire [concat_pkg::data_width-1:0] fifo_data_0;
  wire [concat_pkg::data_width-1:0] fifo_data_1;
  wire [concat_pkg::data_width-1:0] fifo_data_2;
  wire [concat_pkg::data_width-1:0] fifo_data_3;
  wire [concat_pkg::data_width-1:0] fifo_data_4;
  wire                              ovf_0;
  wire                              ovf_1;
  wire                              ovf_2;
  wire                              ovf_3;
  wire                              ovf_4;

  ////////////////////
  // branch buffers
  ////////////////////

  // input no1 feeds branch 0, and so on
  branch_fifo branch_fifo_0 (
    .clk(clk), .reset(reset), .push(valid_in_no1), .push_data(in_no1),
    .pop(fifo_pop[0]), .pop_data(fifo_data_0), .empty(fifo_empty[0]), .overflow(ovf_0)
  );

  branch_fifo branch_fifo_1 (
    .clk(clk), .reset(reset), .push(valid_in_no2), .push_data(in_no2),
    .pop(fifo_pop[1]), .pop_data(fifo_data_1), .empty(fifo_empty[1]), .overflow(ovf_1)
  );

  branch_fifo branch_fifo_2 (
    .clk(clk), .reset(reset), .push(valid_in_no3), .push_data(in_no3),
    .pop(fifo_pop[2]), .pop_data(fifo_data_2), .empty(fifo_empty[2]), .overflow(ovf_2)
  );

  branch_fifo branch_fifo_3 (
    .clk(clk), .reset(reset), .push(valid_in_no4), .push_data(in_no4),
    .pop(fifo_pop[3]), .pop_data(fifo_data_3), .empty(fifo_empty[3]), .overflow(ovf_3)
  );

  // last branch, closes each frame
  branch_fifo branch_fifo_4 (
    .clk(clk), .reset(reset), .push(valid_in_no5), .push_data(in_no5),
    .pop(fifo_pop[4]), .pop_data(fifo_data_4), .empty(fifo_empty[4]), .overflow(ovf_4)
  );

  ////////////////////
  // output sequencing
  ////////////////////

  concat_arbiter concat_arbiter_0 (
    .clk       (clk),
    .reset     (reset),
    .empty     (fifo_empty),
    .pop_data0 (fifo_data_0),
    .pop_data1 (fifo_data_1),
    .pop_data2 (fifo_data_2),
    .pop_data3 (fifo_data_3),
    .pop_data4 (fifo_data_4),
    .pop       (fifo_pop),
    .out       (out),
    .valid_out (valid_out),
    .last_out  (last_out)
  );

  // sticky drop flags, bit 0 is branch 0
  assign overflow = {ovf_4, ovf_3, ovf_2, ovf_1, ovf_0};

endmodule

`default_nettype wire

//--- verification/concat_assertions.sv
// protocol checks bound into the concat top level
// sampled on the rising clock with a synchronous active-high reset

`timescale 1ns/1ps
`default_nettype none

module concat_assertions (
  input wire                              clk,
  input wire                              reset,
  input wire                              valid_out,
  input wire                              last_out,
  input wire [concat_pkg::num_branch-1:0] overflow,
  input wire [concat_pkg::num_branch-1:0] pop,
  input wire [concat_pkg::num_branch-1:0] empty
);

  // number of failed assertions so far
  int fail_count = 0;

  ////////////////////
  // output strobes
  ////////////////////

  // frame end only marks a real word
  last_with_valid: assert property (@(posedge clk) disable iff (reset) last_out |-> valid_out)
    else begin
      $error("last_out high without valid_out");
      fail_count++;
    end

  // output register cleared by reset
  quiet_after_reset: assert property (@(posedge clk) reset |=> !valid_out)
    else begin
      $error("valid_out high in the cycle after reset");
      fail_count++;
    end

  ////////////////////
  // fifo side
  ////////////////////

  // arbiter never pops a branch with nothing in it
  pop_needs_data: assert property (@(posedge clk) disable iff (reset) (pop & empty) == '0)
    else begin
      $error("pop asserted on an empty branch fifo");
      fail_count++;
    end

  // only the granted branch moves
  pop_one_hot: assert property (@(posedge clk) disable iff (reset) $onehot0(pop))
    else begin
      $error("more than one pop line high");
      fail_count++;
    end

  // drop flags only clear through reset
  overflow_sticky: assert property (@(posedge clk) !reset |=> ((~overflow & $past(overflow)) == '0))
    else begin
      $error("overflow bit fell without reset");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- verification/cnn_concat_5in_tb.sv
// drives five interleaved branch streams and checks the concatenated output
// expected order comes from per-branch pending lists walked by seg_len
// the run stops at a cycle limit derived from the table length

`timescale 1ns/1ps
`default_nettype none

module cnn_concat_5in_tb;

  logic                              clk;
  logic                              reset;
  logic [concat_pkg::num_branch-1:0] push_vec;
  logic [concat_pkg::data_width-1:0] in_word [concat_pkg::num_branch];
  wire  [concat_pkg::data_width-1:0] out;
  wire                               valid_out;
  wire                               last_out;
  wire  [concat_pkg::num_branch-1:0] overflow;

  // stimulus table of one row per cycle in several segments
  logic [concat_pkg::num_branch-1:0] tbl_mask [512];
  logic [concat_pkg::data_width-1:0] tbl_data [512][concat_pkg::num_branch];
  int                                num_rows;
  int                                seg_start [10];

  // reference model
  logic [concat_pkg::data_width-1:0] model_mem [concat_pkg::num_branch][512];
  int                                wr_idx [concat_pkg::num_branch];
  int                                rd_idx [concat_pkg::num_branch];
  int                                exp_branch;
  int                                exp_cnt;

  int errors;
  int checks;
  int last_count;
  int cycles;
  int cycle_limit = 200;

  cnn_concat_5in cnn_concat_5in_i (
    .clk(clk), .reset(reset),
    .valid_in_no1(push_vec[0]), .in_no1(in_word[0]),
    .valid_in_no2(push_vec[1]), .in_no2(in_word[1]),
    .valid_in_no3(push_vec[2]), .in_no3(in_word[2]),
    .valid_in_no4(push_vec[3]), .in_no4(in_word[3]),
    .valid_in_no5(push_vec[4]), .in_no5(in_word[4]),
    .out(out), .valid_out(valid_out), .last_out(last_out), .overflow(overflow)
  );

  bind cnn_concat_5in concat_assertions concat_assertions_i (
    .clk(clk), .reset(reset), .valid_out(valid_out), .last_out(last_out),
    .overflow(overflow), .pop(fifo_pop), .empty(fifo_empty)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  ////////////////////
  // output checker and model update on the falling edge
  ////////////////////

  always @(negedge clk) begin
    int pending;
    logic [concat_pkg::data_width-1:0] want;
    logic want_last;
    if (valid_out) begin
      pending   = wr_idx[exp_branch] - rd_idx[exp_branch];
      want_last = (exp_branch == concat_pkg::num_branch - 1) &&
                  (exp_cnt == int'(concat_pkg::seg_len[exp_branch]) - 1);
      checks++;
      assert (pending > 0) else begin
        $display("output word %h at %0t ns came while branch %0d had nothing pending",
                 out, $time, exp_branch);
        errors++;
      end
      if (pending > 0) begin
        want = model_mem[exp_branch][rd_idx[exp_branch]];
        rd_idx[exp_branch]++;
        assert (out == want) else begin
          $display("Fail at %0t ns: branch %0d word %0d expected %h got %h",
                   $time, exp_branch, exp_cnt, want, out);
          errors++;
        end
      end
      assert (last_out == want_last) else begin
        $display("Fail at %0t ns: last_out expected %0b got %0b", $time, want_last, last_out);
        errors++;
      end
      if (last_out) begin
        last_count++;
      end
      // step through the frame in branch order 0..4
      if (exp_cnt == int'(concat_pkg::seg_len[exp_branch]) - 1) begin
        exp_cnt    = 0;
        exp_branch = (exp_branch + 1) % concat_pkg::num_branch;
      end else begin
        exp_cnt++;
      end
    end
    if (reset) begin
      // dut drops all buffered words
      for (int b = 0; b < concat_pkg::num_branch; b++) begin
        rd_idx[b] = wr_idx[b];
      end
      exp_branch = 0;
      exp_cnt    = 0;
    end else begin
      // full branch loses the word
      for (int b = 0; b < concat_pkg::num_branch; b++) begin
        if (push_vec[b] && (wr_idx[b] - rd_idx[b] < concat_pkg::fifo_depth)) begin
          model_mem[b][wr_idx[b]] = in_word[b];
          wr_idx[b]++;
        end
      end
    end
  end

  ////////////////////
  // table building
  ////////////////////

  task automatic add_row(input logic [concat_pkg::num_branch-1:0] mask);
    tbl_mask[num_rows] = mask;
    for (int b = 0; b < concat_pkg::num_branch; b++) begin
      tbl_data[num_rows][b] = $urandom;
    end
    num_rows++;
  endtask

  // random interleave until each branch has pushed its count
  task automatic fill_random(input int n0, input int n1, input int n2, input int n3,
                             input int n4);
    int need [concat_pkg::num_branch];
    int left;
    logic [concat_pkg::num_branch-1:0] mask;
    need = '{n0, n1, n2, n3, n4};
    left = n0 + n1 + n2 + n3 + n4;
    while (left > 0) begin
      mask = concat_pkg::num_branch'($urandom);
      for (int b = 0; b < concat_pkg::num_branch; b++) begin
        if (need[b] == 0) begin
          mask[b] = 1'b0;
        end else if (mask[b]) begin
          need[b]--;
          left--;
        end
      end
      add_row(mask);
    end
  endtask

  task automatic build_table;
    num_rows = 0;
    // two frames with branch 4 leading
    seg_start[0] = num_rows;
    repeat (4) add_row(5'b10000);
    fill_random(6, 10, 4, 8, 8);
    // one frame with segments in reverse branch order and gaps
    seg_start[1] = num_rows;
    for (int b = concat_pkg::num_branch - 1; b >= 0; b--) begin
      repeat (concat_pkg::seg_len[b]) add_row(concat_pkg::num_branch'(1 << b));
      add_row('0);
    end
    // branch 2 held back while 3 and 4 sit loaded
    seg_start[2] = num_rows;
    fill_random(3, 5, 0, 4, 6);
    repeat (16) add_row('0);
    seg_start[3] = num_rows;
    repeat (2) add_row(5'b00100);
    // all strobes together and then the rest of two frames
    seg_start[4] = num_rows;
    repeat (4) add_row(5'b11111);
    fill_random(2, 6, 0, 4, 8);
    // 17 words on branch 4 with the grant parked on empty branch 0
    seg_start[5] = num_rows;
    repeat (17) add_row(5'b10000);
    seg_start[6] = num_rows;
    fill_random(6, 10, 4, 8, 0);
    // partial frame followed by reset and a fresh frame
    seg_start[7] = num_rows;
    fill_random(3, 2, 0, 0, 0);
    repeat (6) add_row('0);
    seg_start[8] = num_rows;
    fill_random(3, 5, 2, 4, 6);
    seg_start[9] = num_rows;
  endtask

  ////////////////////
  // sequencing
  ////////////////////

  task run_seg(input int k);
    for (int r = seg_start[k]; r < seg_start[k + 1]; r++) begin
      @(posedge clk);
      push_vec <= tbl_mask[r];
      in_word  <= tbl_data[r];
    end
    @(posedge clk);
    push_vec <= '0;
  endtask

  task apply_reset;
    @(posedge clk);
    reset    <= 1'b1;
    push_vec <= '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
  endtask

  // wait until the granted branch has nothing left to give
  task drain;
    @(posedge clk);
    while (wr_idx[exp_branch] != rd_idx[exp_branch]) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);
  endtask

  task expect_overflow(input logic [concat_pkg::num_branch-1:0] want);
    @(negedge clk);
    checks++;
    assert (overflow == want) else begin
      $display("Fail at %0t ns: overflow expected %b got %b", $time, want, overflow);
      errors++;
    end
  endtask

  task close_test(input int num, input string name, input int err_mark, input int last_mark,
                  input int frames);
    checks++;
    assert (last_count - last_mark == frames) else begin
      $display("Fail at %0t ns: test %0d expected %0d frame ends, saw %0d",
               $time, num, frames, last_count - last_mark);
      errors++;
    end
    $display("test %0d %s: %s", num, name, (errors == err_mark) ? "ok" : "failed");
  endtask

  initial begin
    int err_mark;
    int last_mark;
    int assert_fails;
    reset      = 1'b1;
    push_vec   = '0;
    in_word    = '{default: '0};
    wr_idx     = '{default: 0};
    rd_idx     = '{default: 0};
    exp_branch = 0;
    exp_cnt    = 0;
    errors     = 0;
    checks     = 0;
    last_count = 0;
    cycles     = 0;
    void'($urandom(32'h2e93_42f9));
    build_table();
    cycle_limit = 4 * num_rows + 200;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    err_mark  = errors;
    last_mark = last_count;
    run_seg(0);
    drain();
    expect_overflow('0);
    close_test(1, "interleaved order", err_mark, last_mark, 2);

    err_mark  = errors;
    last_mark = last_count;
    run_seg(1);
    drain();
    close_test(2, "frame marking", err_mark, last_mark, 1);

    err_mark  = errors;
    last_mark = last_count;
    run_seg(2);
    checks++;
    assert (exp_branch == 2 && wr_idx[3] - rd_idx[3] == 4 && wr_idx[4] - rd_idx[4] == 6)
    else begin
      $display("Fail at %0t ns: stall expected on branch 2, model waits on branch %0d",
               $time, exp_branch);
      errors++;
    end
    run_seg(3);
    drain();
    close_test(3, "stall without skip", err_mark, last_mark, 1);

    err_mark  = errors;
    last_mark = last_count;
    run_seg(4);
    drain();
    expect_overflow('0);
    close_test(4, "simultaneous pushes", err_mark, last_mark, 2);

    err_mark  = errors;
    last_mark = last_count;
    run_seg(5);
    expect_overflow(5'b10000);
    run_seg(6);
    drain();
    expect_overflow(5'b10000);
    close_test(5, "overflow drop", err_mark, last_mark, 2);

    err_mark  = errors;
    last_mark = last_count;
    run_seg(7);
    apply_reset();
    expect_overflow('0);
    run_seg(8);
    drain();
    expect_overflow('0);
    close_test(6, "reset recovery", err_mark, last_mark, 1);

    // protocol assertion failures count as errors too
    assert_fails = cnn_concat_5in_i.concat_assertions_i.fail_count;
    errors       = errors + assert_fails;
    $display("summary: %0d checks, %0d errors (%0d from assertions), %0d frame ends, %0d cycles",
             checks, errors, assert_fails, last_count, cycles);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
verilog/concat_pkg.sv
verilog/branch_fifo.sv
verilog/concat_arbiter.sv
verilog/cnn_concat_5in.sv
verification/concat_assertions.sv
verification/cnn_concat_5in_tb.sv

//--- run.sh
#!/bin/sh
# build the concat testbench with verilator and run it
# the run passes only when the pass message shows up in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cnn_concat_5in_tb \
  -f list.f -o concat_sim \
  && ./obj_dir/concat_sim | tee /dev/stderr | grep "ALL CHECKS PASSED" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
